// File: hw/tile_map_pkg.sv
package tile_map_pkg;

  // rgb444 pixel colour
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb_t;

  // tile states held in the map, codes 9..15 are unused
  typedef enum logic [3:0] {
    no_blk,
    perm_blk,
    destroyable_blk,
    player_spawn,
    enemy,
    bomb,
    explosion,
    power_up,
    border
  } tile_state_t;

  // screen coordinate
  typedef struct packed {
    logic [10:0] x;
    logic [9:0]  y;
  } pos_t;

  // video control levels that travel with a pixel
  typedef struct packed {
    logic hsync;  // active low
    logic vsync;  // active low
    logic active;
  } sync_t;

  // player box touches this side of the play field
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
  } edge_t;

  // movement request
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
  } dir_t;

  // blanking levels, both syncs released
  localparam sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, active: 1'b0};

  function automatic rgb_t tile_color(input tile_state_t state);
    rgb_t rgb;
    case (state)
      no_blk:          rgb = 12'h000; // black floor
      perm_blk:        rgb = 12'hFFF;
      destroyable_blk: rgb = 12'h00F;
      player_spawn:    rgb = 12'h0FF;
      enemy:           rgb = 12'hF33;
      bomb:            rgb = 12'h333;
      explosion:       rgb = 12'hF00;
      power_up:        rgb = 12'h0F0;
      border:          rgb = 12'hFFF;
      default:         rgb = 12'hFF0; // yellow flags a bad code in the map
    endcase
    return rgb;
  endfunction

endpackage

// File: hw/raster_timing.sv
module raster_timing #(
  parameter int H_ACTIVE     = 1280,
  parameter int H_TOTAL      = 1680,
  parameter int H_SYNC_START = 1344,
  parameter int H_SYNC_LEN   = 136,
  parameter int V_ACTIVE     = 800,
  parameter int V_TOTAL      = 828,
  parameter int V_SYNC_START = 801,
  parameter int V_SYNC_LEN   = 3
) (
  input  logic                clk,
  input  logic                i_rst,
  output tile_map_pkg::pos_t  o_pos,
  output tile_map_pkg::sync_t o_sync,
  output logic                o_frame_start
);

  logic [10:0] h_cnt;  // pixel within line
  logic [9:0]  v_cnt;  // line within frame
  logic        h_last;
  logic        v_last;

  assign h_last = (h_cnt == 11'(H_TOTAL - 1));
  assign v_last = (v_cnt == 10'(V_TOTAL - 1));

  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      h_cnt         <= '0;
      v_cnt         <= '0;
      o_frame_start <= 1'b0;
    end
    else
    begin
      // registered so the strobe is high exactly while the counters read 0,0
      o_frame_start <= h_last && v_last;
      if (h_last)
      begin
        h_cnt <= '0;
        v_cnt <= v_last ? '0 : v_cnt + 10'd1; // next line, or wrap the frame
      end
      else
      begin
        h_cnt <= h_cnt + 11'd1;
      end
    end
  end

  assign o_pos.x = h_cnt;
  assign o_pos.y = v_cnt;

  // sync pulses are low inside their windows
  assign o_sync.hsync  = !((h_cnt >= 11'(H_SYNC_START)) &&
                           (h_cnt < 11'(H_SYNC_START + H_SYNC_LEN)));
  assign o_sync.vsync  = !((v_cnt >= 10'(V_SYNC_START)) &&
                           (v_cnt < 10'(V_SYNC_START + V_SYNC_LEN)));
  assign o_sync.active = (h_cnt < 11'(H_ACTIVE)) && (v_cnt < 10'(V_ACTIVE));

  a_cnt_range: assert property (@(posedge clk) disable iff (i_rst)
    (h_cnt < 11'(H_TOTAL)) && (v_cnt < 10'(V_TOTAL)));

endmodule

// File: hw/map_ram.sv
module map_ram #(
  parameter int NUM_COL = 19,
  parameter int NUM_ROW = 11,
  localparam int NUM_TILES = NUM_COL * NUM_ROW,
  localparam int ADDR_W    = $clog2(NUM_TILES)
) (
  input  logic                      clk,
  input  logic                      i_we,
  input  logic [ADDR_W-1:0]         i_waddr,
  input  tile_map_pkg::tile_state_t i_wdata,
  input  logic [ADDR_W-1:0]         i_raddr,
  output tile_map_pkg::tile_state_t o_rdata
);
  import tile_map_pkg::*;

  // one state per tile, row-major
  tile_state_t mem [NUM_TILES];

  always_ff @(posedge clk)
  begin
    if (i_we)
    begin
      mem[i_waddr] <= i_wdata;
    end
    o_rdata <= mem[i_raddr]; // read-before-write on a shared address
  end

  // writes from outside must land on a real tile
  a_waddr_range: assert property (@(posedge clk)
    i_we |-> (int'(i_waddr) < NUM_TILES));

endmodule

// File: hw/tile_renderer.sv
module tile_renderer #(
  parameter int H_ACTIVE    = 1280,
  parameter int V_ACTIVE    = 800,
  parameter int BRD_SIDE    = 32,
  parameter int BRD_TOP     = 96,
  parameter int TILE_W_LOG2 = 6,
  parameter int TILE_H_LOG2 = 6,
  parameter int NUM_COL     = 19,
  parameter int NUM_ROW     = 11,
  parameter int PLAYER_W    = 64,
  parameter int PLAYER_H    = 64,
  localparam int NUM_TILES  = NUM_COL * NUM_ROW,
  localparam int ADDR_W     = $clog2(NUM_TILES)
) (
  input  logic                      clk,
  input  logic                      i_rst,
  input  tile_map_pkg::pos_t        i_pos,
  input  tile_map_pkg::sync_t       i_sync,
  input  tile_map_pkg::tile_state_t i_tile,
  input  tile_map_pkg::pos_t        i_player_pos,
  input  tile_map_pkg::rgb_t        i_player_rgb,
  output logic [ADDR_W-1:0]         o_raddr,
  output tile_map_pkg::rgb_t        o_rgb,
  output tile_map_pkg::sync_t       o_sync,
  output tile_map_pkg::edge_t       o_edges
);
  import tile_map_pkg::*;

  localparam logic [10:0] FIELD_X0 = 11'(BRD_SIDE);            // first field column
  localparam logic [10:0] FIELD_X1 = 11'(H_ACTIVE - BRD_SIDE); // one past last column
  localparam logic [9:0]  FIELD_Y0 = 10'(BRD_TOP);
  localparam logic [9:0]  FIELD_Y1 = 10'(V_ACTIVE);            // no bottom border
  localparam logic [10:0] BOX_W    = 11'(PLAYER_W);
  localparam logic [9:0]  BOX_H    = 10'(PLAYER_H);

  logic        in_field;
  logic [10:0] map_x;
  logic [9:0]  map_y;
  logic [10:0] col;
  logic [9:0]  row;
  logic [20:0] lin_addr;
  pos_t        pos_d1;
  pos_t        pos_d2;
  sync_t       sync_d1;
  sync_t       sync_d2;
  logic        in_field_d1;
  logic        in_field_d2;
  tile_state_t tile_q;      // stage 2 tile state
  logic        player_hit;

  // stage 0, address from the raster position
  always_comb
  begin
    in_field = (i_pos.x >= FIELD_X0) && (i_pos.x < FIELD_X1) &&
               (i_pos.y >= FIELD_Y0) && (i_pos.y < FIELD_Y1);
    map_x    = i_pos.x - FIELD_X0; // wraps for border pixels, masked in stage 2
    map_y    = i_pos.y - FIELD_Y0;
    col      = map_x >> TILE_W_LOG2;
    row      = map_y >> TILE_H_LOG2;
    lin_addr = 21'(row) * 21'(NUM_COL) + 21'(col); // row-major index
  end

  assign o_raddr = lin_addr[ADDR_W-1:0];

  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      sync_d1     <= SYNC_IDLE;
      sync_d2     <= SYNC_IDLE;
      in_field_d1 <= 1'b0;
      in_field_d2 <= 1'b0;
      tile_q      <= border;
    end
    else
    begin
      sync_d1     <= i_sync;  // stage 1 waits on the ram read
      sync_d2     <= sync_d1;
      in_field_d1 <= in_field;
      in_field_d2 <= in_field_d1;
      tile_q      <= in_field_d1 ? i_tile : border;
    end
  end

  // pixel position follows its tile through both stages
  always_ff @(posedge clk)
  begin
    pos_d1 <= i_pos;
    pos_d2 <= pos_d1;
  end

  // player box compared against the delayed pixel
  assign player_hit = in_field_d2 &&
                      (pos_d2.x >= i_player_pos.x) && (pos_d2.x < i_player_pos.x + BOX_W) &&
                      (pos_d2.y >= i_player_pos.y) && (pos_d2.y < i_player_pos.y + BOX_H);

  always_comb
  begin
    o_rgb = tile_color(tile_q);
    if (player_hit)
    begin
      o_rgb = i_player_rgb; // player drawn over the tile
    end
    if (!sync_d2.active)
    begin
      o_rgb = '0;           // black in blanking
    end
  end

  assign o_sync = sync_d2;

  // edge contact of the player box, inclusive on each side
  always_comb
  begin
    o_edges.right = (i_player_pos.x + BOX_W >= FIELD_X1);
    o_edges.left  = (i_player_pos.x <= FIELD_X0);
    o_edges.down  = (i_player_pos.y + BOX_H >= FIELD_Y1);
    o_edges.up    = (i_player_pos.y <= FIELD_Y0);
  end

  // an in-field pixel always maps to a tile that exists in map_ram
  a_addr_range: assert property (@(posedge clk) disable iff (i_rst)
    in_field |-> (int'(lin_addr) < NUM_TILES));

endmodule

// File: hw/player_ctrl.sv
module player_ctrl #(
  parameter int STEP      = 8,
  parameter int PLAYER_X0 = 96,
  parameter int PLAYER_Y0 = 160
) (
  input  logic                clk,
  input  logic                i_rst,
  input  logic                i_frame_start,
  input  tile_map_pkg::dir_t  i_dir,
  input  tile_map_pkg::edge_t i_edges,
  output tile_map_pkg::pos_t  o_player_pos
);
  import tile_map_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_decide,
    st_move
  } state_t;

  localparam logic [10:0] STEP_X = 11'(STEP);
  localparam logic [9:0]  STEP_Y = 10'(STEP);

  state_t state_q;
  dir_t   dir_q;   // request sampled on frame start
  dir_t   sel_d;
  dir_t   sel_q;   // one-hot step chosen in decide

  // first unblocked request wins, right then left then down then up
  always_comb
  begin
    sel_d = '0;
    if (dir_q.right && !i_edges.right)
      sel_d.right = 1'b1;
    else if (dir_q.left && !i_edges.left)
      sel_d.left = 1'b1;
    else if (dir_q.down && !i_edges.down)
      sel_d.down = 1'b1;
    else if (dir_q.up && !i_edges.up)
      sel_d.up = 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      state_q        <= st_idle;
      dir_q          <= '0;
      sel_q          <= '0;
      o_player_pos.x <= 11'(PLAYER_X0);
      o_player_pos.y <= 10'(PLAYER_Y0);
    end
    else
    begin
      case (state_q)
        st_idle:
        begin
          if (i_frame_start)
          begin
            dir_q   <= i_dir;
            state_q <= st_decide;
          end
        end
        st_decide:
        begin
          sel_q   <= sel_d; // all zero when every request is blocked
          state_q <= st_move;
        end
        st_move:
        begin
          if (sel_q.right)
            o_player_pos.x <= o_player_pos.x + STEP_X;
          else if (sel_q.left)
            o_player_pos.x <= o_player_pos.x - STEP_X;
          else if (sel_q.down)
            o_player_pos.y <= o_player_pos.y + STEP_Y;
          else if (sel_q.up)
            o_player_pos.y <= o_player_pos.y - STEP_Y;
          state_q <= st_idle;
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // the step taken in move never heads into a side flagged during decide
  a_no_blocked_move: assert property (@(posedge clk) disable iff (i_rst)
    (state_q == st_move) |=>
      (!$past(i_edges.right, 2) || (o_player_pos.x <= $past(o_player_pos.x, 2))) &&
      (!$past(i_edges.left, 2)  || (o_player_pos.x >= $past(o_player_pos.x, 2))) &&
      (!$past(i_edges.down, 2)  || (o_player_pos.y <= $past(o_player_pos.y, 2))) &&
      (!$past(i_edges.up, 2)    || (o_player_pos.y >= $past(o_player_pos.y, 2))));

endmodule

// File: hw/game_display_top.sv
module game_display_top #(
  parameter int H_ACTIVE     = 1280,
  parameter int H_TOTAL      = 1680,
  parameter int H_SYNC_START = 1344,
  parameter int H_SYNC_LEN   = 136,
  parameter int V_ACTIVE     = 800,
  parameter int V_TOTAL      = 828,
  parameter int V_SYNC_START = 801,
  parameter int V_SYNC_LEN   = 3,
  parameter int BRD_SIDE     = 32,
  parameter int BRD_TOP      = 96,
  parameter int TILE_W_LOG2  = 6,
  parameter int TILE_H_LOG2  = 6,
  parameter int NUM_COL      = 19,
  parameter int NUM_ROW      = 11,
  parameter int PLAYER_W     = 64,
  parameter int PLAYER_H     = 64,
  parameter int STEP         = 8,
  parameter int PLAYER_X0    = 96,
  parameter int PLAYER_Y0    = 160,
  localparam int ADDR_W      = $clog2(NUM_COL * NUM_ROW)
) (
  input  logic                      clk,
  input  logic                      i_rst,
  input  logic                      i_map_we,
  input  logic [ADDR_W-1:0]         i_map_waddr,
  input  tile_map_pkg::tile_state_t i_map_wdata,
  input  tile_map_pkg::dir_t        i_dir,
  input  tile_map_pkg::rgb_t        i_player_rgb,
  output tile_map_pkg::rgb_t        o_rgb,
  output tile_map_pkg::sync_t       o_sync,
  output tile_map_pkg::pos_t        o_player_pos
);
  import tile_map_pkg::*;

  pos_t              raster_pos;
  sync_t             raster_sync;
  logic              frame_start;
  logic [ADDR_W-1:0] map_raddr;
  tile_state_t       map_rdata;
  edge_t             player_edges;  // renderer to controller

  raster_timing #(
    .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL),
    .H_SYNC_START(H_SYNC_START), .H_SYNC_LEN(H_SYNC_LEN),
    .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
    .V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN)
  ) raster_timing_i (
    .clk(clk), .i_rst(i_rst),
    .o_pos(raster_pos), .o_sync(raster_sync), .o_frame_start(frame_start)
  );

  map_ram #(.NUM_COL(NUM_COL), .NUM_ROW(NUM_ROW)) map_ram_i (
    .clk(clk), .i_we(i_map_we), .i_waddr(i_map_waddr), .i_wdata(i_map_wdata),
    .i_raddr(map_raddr), .o_rdata(map_rdata)
  );

  tile_renderer #(
    .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE),
    .BRD_SIDE(BRD_SIDE), .BRD_TOP(BRD_TOP),
    .TILE_W_LOG2(TILE_W_LOG2), .TILE_H_LOG2(TILE_H_LOG2),
    .NUM_COL(NUM_COL), .NUM_ROW(NUM_ROW),
    .PLAYER_W(PLAYER_W), .PLAYER_H(PLAYER_H)
  ) tile_renderer_i (
    .clk(clk), .i_rst(i_rst),
    .i_pos(raster_pos), .i_sync(raster_sync), .i_tile(map_rdata),
    .i_player_pos(o_player_pos), .i_player_rgb(i_player_rgb),
    .o_raddr(map_raddr), .o_rgb(o_rgb), .o_sync(o_sync), .o_edges(player_edges)
  );

  player_ctrl #(.STEP(STEP), .PLAYER_X0(PLAYER_X0), .PLAYER_Y0(PLAYER_Y0)) player_ctrl_i (
    .clk(clk), .i_rst(i_rst),
    .i_frame_start(frame_start), .i_dir(i_dir), .i_edges(player_edges),
    .o_player_pos(o_player_pos)
  );

endmodule

// File: dv/tb_game_display.sv
module tb_game_display;
  timeunit 1ns;
  timeprecision 100ps;
  import tile_map_pkg::*;

  localparam int H_ACTIVE = 28;
  localparam int H_TOTAL = 36;
  localparam int H_SYNC_START = 30;
  localparam int H_SYNC_LEN = 3;
  localparam int V_ACTIVE = 20;
  localparam int V_TOTAL = 24;
  localparam int V_SYNC_START = 21;
  localparam int V_SYNC_LEN = 2;
  localparam int BRD_SIDE = 4;
  localparam int BRD_TOP = 8;
  localparam int TILE_W = 4;
  localparam int TILE_H = 4;
  localparam int NUM_COL = 5;
  localparam int NUM_ROW = 3;
  localparam int NUM_TILES = NUM_COL * NUM_ROW;
  localparam int ADDR_W = $clog2(NUM_TILES);
  localparam int PLAYER_W = 4;
  localparam int PLAYER_H = 4;
  localparam int STEP = 4;
  localparam int PLAYER_X0 = 8;
  localparam int PLAYER_Y0 = 12;
  localparam int FRAME_LEN = H_TOTAL * V_TOTAL;
  localparam int NUM_TESTS = 7;
  localparam int MAX_FRAMES = 4;
  localparam int CYCLE_LIMIT = (NUM_TESTS * (MAX_FRAMES + 1) + 3) * FRAME_LEN; // + reset frame

  localparam logic [1:0] MAP_FILL = 2'd0;
  localparam logic [1:0] MAP_RANDOM = 2'd1;
  localparam logic [1:0] MAP_RAMP = 2'd2;

  typedef struct packed {
    logic [1:0] map_mode;
    logic [3:0] fill;        // state code for fill mode
    dir_t       dir;
    rgb_t       player_rgb;
    logic [3:0] frames;      // checked frames after the setup frame
  } test_row_t;

  // dir is right,left,down,up
  test_row_t tests [NUM_TESTS] = '{
    '{MAP_RAMP,   4'h0, 4'b0000, 12'h5A3, 4'd1},
    '{MAP_RANDOM, 4'h0, 4'b0000, 12'h8C1, 4'd1},
    '{MAP_FILL,   4'h1, 4'b1000, 12'h719, 4'd4},  // perm_blk map while walking into the right edge
    '{MAP_FILL,   4'h5, 4'b1000, 12'h2E6, 4'd2},  // bomb map with the right side still blocked
    '{MAP_RANDOM, 4'h0, 4'b0010, 12'hC4A, 4'd3},
    '{MAP_FILL,   4'hB, 4'b0101, 12'h39F, 4'd2},  // undefined code while left wins over up
    '{MAP_FILL,   4'h0, 4'b0000, 12'hE07, 4'd1}
  };
  string names [NUM_TESTS] = '{"state ramp", "random map", "step right", "right blocked",
                               "step down", "left over up", "idle"};

  logic              clk;
  logic              i_rst;
  logic              i_map_we;
  logic [ADDR_W-1:0] i_map_waddr;
  tile_state_t       i_map_wdata;
  dir_t              i_dir;
  rgb_t              player_rgb;
  rgb_t              o_rgb;
  sync_t             o_sync;
  pos_t              o_player_pos;

  logic        check_en;
  int          n_checks;
  int          n_errors;
  int          cycle_cnt;
  logic [10:0] m_x;          // model raster
  logic [9:0]  m_y;
  pos_t        m_p1;         // model pixel pipeline
  pos_t        m_p2;
  logic        m_v1;
  logic        m_v2;
  logic        m_fs;         // model frame start
  pos_t        m_player;
  tile_state_t m_map [NUM_TILES];

  game_display_top #(
    .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .H_SYNC_START(H_SYNC_START),
    .H_SYNC_LEN(H_SYNC_LEN), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL),
    .V_SYNC_START(V_SYNC_START), .V_SYNC_LEN(V_SYNC_LEN),
    .BRD_SIDE(BRD_SIDE), .BRD_TOP(BRD_TOP), .TILE_W_LOG2(2), .TILE_H_LOG2(2),
    .NUM_COL(NUM_COL), .NUM_ROW(NUM_ROW), .PLAYER_W(PLAYER_W), .PLAYER_H(PLAYER_H),
    .STEP(STEP), .PLAYER_X0(PLAYER_X0), .PLAYER_Y0(PLAYER_Y0)
  ) game_display_top_i (
    .clk(clk), .i_rst(i_rst), .i_map_we(i_map_we), .i_map_waddr(i_map_waddr),
    .i_map_wdata(i_map_wdata), .i_dir(i_dir), .i_player_rgb(player_rgb),
    .o_rgb(o_rgb), .o_sync(o_sync), .o_player_pos(o_player_pos)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // first unblocked request in order right, left, down, up
  function automatic pos_t next_player(input pos_t p, input dir_t d);
    pos_t n;
    n = p;
    if (d.right && int'(p.x) + PLAYER_W < H_ACTIVE - BRD_SIDE)
      n.x = 11'(int'(p.x) + STEP);
    else if (d.left && int'(p.x) > BRD_SIDE)
      n.x = 11'(int'(p.x) - STEP);
    else if (d.down && int'(p.y) + PLAYER_H < V_ACTIVE)
      n.y = 10'(int'(p.y) + STEP);
    else if (d.up && int'(p.y) > BRD_TOP)
      n.y = 10'(int'(p.y) - STEP);
    return n;
  endfunction

  // on-screen colour of each map code
  function automatic rgb_t state_rgb(input tile_state_t state);
    rgb_t c;
    case (state)
      no_blk:          c = 12'h000;  // black
      perm_blk:        c = 12'hFFF;  // white
      destroyable_blk: c = 12'h00F;  // blue
      player_spawn:    c = 12'h0FF;  // cyan
      enemy:           c = 12'hF33;
      bomb:            c = 12'h333;
      explosion:       c = 12'hF00;  // red
      power_up:        c = 12'h0F0;  // green
      border:          c = 12'hFFF;
      default:         c = 12'hFF0;  // unused codes show yellow
    endcase
    return c;
  endfunction

  function automatic sync_t exp_sync(input pos_t p, input logic valid);
    sync_t s;
    int    x;
    int    y;
    x = int'(p.x);
    y = int'(p.y);
    s = '{hsync: 1'b1, vsync: 1'b1, active: 1'b0};  // blanking after reset
    if (valid)
    begin
      s.hsync  = !(x >= H_SYNC_START && x < H_SYNC_START + H_SYNC_LEN);
      s.vsync  = !(y >= V_SYNC_START && y < V_SYNC_START + V_SYNC_LEN);
      s.active = (x < H_ACTIVE) && (y < V_ACTIVE);
    end
    return s;
  endfunction

  function automatic rgb_t exp_rgb(input pos_t p, input logic valid);
    int px;
    int py;
    int x;
    int y;
    x  = int'(p.x);
    y  = int'(p.y);
    px = int'(m_player.x);
    py = int'(m_player.y);
    if (!valid || x >= H_ACTIVE || y >= V_ACTIVE)
      return '0;
    if (x < BRD_SIDE || x >= H_ACTIVE - BRD_SIDE || y < BRD_TOP)
      return state_rgb(border);  // side and top border
    if (x >= px && x < px + PLAYER_W && y >= py && y < py + PLAYER_H)
      return player_rgb;
    return state_rgb(m_map[((y - BRD_TOP) / TILE_H) * NUM_COL + (x - BRD_SIDE) / TILE_W]);
  endfunction

  task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_sync(input string name, input sync_t got, input sync_t exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("mismatch at %0d ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_pos(input string name, input pos_t got, input pos_t exp);
    n_checks++;
    if (got !== exp)
    begin
      n_errors++;
      $display("mismatch at %0d ns: %s got %0d,%0d expected %0d,%0d",
               $time, name, got.x, got.y, exp.x, exp.y);
    end
  endtask

  // model raster, two-stage pixel pipeline and player movement
  always @(posedge clk)
  begin
    if (i_rst)
    begin
      m_x      <= '0;
      m_y      <= '0;
      m_v1     <= 1'b0;
      m_v2     <= 1'b0;
      m_fs     <= 1'b0;
      m_player <= '{x: 11'(PLAYER_X0), y: 10'(PLAYER_Y0)};
    end
    else
    begin
      m_p1 <= '{x: m_x, y: m_y};
      m_p2 <= m_p1;
      m_v1 <= 1'b1;
      m_v2 <= m_v1;
      m_fs <= (m_x == 11'(H_TOTAL - 1)) && (m_y == 10'(V_TOTAL - 1));
      if (m_fs)
        m_player <= next_player(m_player, i_dir);  // dir taken at the end of the strobe
      if (m_x == 11'(H_TOTAL - 1))
      begin
        m_x <= '0;
        m_y <= (m_y == 10'(V_TOTAL - 1)) ? '0 : m_y + 10'd1;
      end
      else
        m_x <= m_x + 11'd1;
    end
  end

  // outputs sampled mid-cycle
  always @(negedge clk)
  begin
    if (check_en)
    begin
      check_sync("o_sync", o_sync, exp_sync(m_p2, m_v2));
      check_rgb("o_rgb", o_rgb, exp_rgb(m_p2, m_v2));
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT)
    begin
      $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
      $display("Result: FAILED");
      $finish;
    end
  end

  // runs to the last pixel of the frame, checks the player, steps into frame start
  task automatic next_frame;
    do
    begin
      @(posedge clk);
      #2;
    end while (!(m_x == 11'(H_TOTAL - 1) && m_y == 10'(V_TOTAL - 1)));
    check_pos("o_player_pos", o_player_pos, m_player);
    @(posedge clk);
    #2;
  endtask

  task automatic load_map(input logic [1:0] mode, input logic [3:0] fill);
    tile_state_t st;
    for (int a = 0; a < NUM_TILES; a++)
    begin
      case (mode)
        MAP_RANDOM: st = tile_state_t'(4'($urandom_range(15, 0)));
        MAP_RAMP:   st = tile_state_t'(4'(a < 10 ? a : a - 8)); // codes 0..9 then 2..6
        default:    st = tile_state_t'(fill);
      endcase
      i_map_we    = 1'b1;
      i_map_waddr = ADDR_W'(a);
      i_map_wdata = st;
      m_map[a]    = st;
      @(posedge clk);
      #2;
    end
    i_map_we = 1'b0;
  endtask

  task automatic report_test(input int num, input string name, input int errs);
    if (errs == 0)
      $display("test %0d %s: ok", num, name);
    else
      $display("test %0d %s: %0d errors", num, name, errs);
  endtask

  initial
  begin
    int          err_start;
    test_row_t   row;
    void'($urandom(32'h41cf));
    i_rst       = 1'b1;
    i_map_we    = 1'b0;
    i_map_waddr = '0;
    i_map_wdata = no_blk;
    i_dir       = '0;
    player_rgb  = '0;
    check_en    = 1'b0;
    n_checks    = 0;
    n_errors    = 0;
    cycle_cnt   = 0;
    @(posedge clk);
    #2;
    check_en = 1'b1;  // reset levels and the first border lines
    repeat (2) @(posedge clk);
    #2;
    i_rst = 1'b0;
    while (m_y < 10'(BRD_TOP))
    begin
      @(posedge clk);
      #2;
    end
    check_en = 1'b0;
    report_test(0, "reset", n_errors);
    next_frame;
    for (int t = 0; t < NUM_TESTS; t++)
    begin
      row        = tests[t];
      err_start  = n_errors;
      i_dir      = row.dir;
      player_rgb = row.player_rgb;
      load_map(row.map_mode, row.fill);  // setup frame is not checked
      next_frame;
      check_en = 1'b1;
      repeat (int'(row.frames)) next_frame;
      check_en = 1'b0;
      report_test(t + 1, names[t], n_errors - err_start);
    end
    $display("tests %0d, checks %0d, errors %0d", NUM_TESTS + 1, n_checks, n_errors);
    if (n_errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// File: game_display_top.f
hw/tile_map_pkg.sv
hw/raster_timing.sv
hw/map_ram.sv
hw/tile_renderer.sv
hw/player_ctrl.sv
hw/game_display_top.sv
dv/tb_game_display.sv

// File: Makefile
# Verilator build and run of the tile-map display testbench

TOP       ?= tb_game_display
FILELIST  ?= game_display_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: TOP FILELIST BUILD_DIR LOG VERILATOR VFLAGS"

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
